// ==== rtl/host_pkg.sv ====
package host_pkg;

  // --------------------------------------------------
  // OSD status word
  // --------------------------------------------------

  localparam int status_width = 64;

  // Bit positions of the settings inside the status word
  localparam int status_reset_bit = 0;
  localparam int status_sound_bit = 1;
  localparam int status_speed_lsb = 2;
  localparam int status_speed_msb = 4;

  // Download index that carries the program ROM image
  localparam logic [15:0] rom_index = 16'd0;

  // One beat of the host download stream
  typedef struct packed {
    logic        download;
    logic [15:0] index;
    logic        wr;
    logic [26:0] addr;
    logic [15:0] dout;
  } ioctl_beat_t;

  // Settings decoded from the status word
  typedef struct packed {
    logic       external_reset;
    // Status bit 1 is sound off, so this is its inverse
    logic       sound_on;
    logic [2:0] speed;
  } settings_t;

  // --------------------------------------------------
  // Joystick word, read as pad or as savestate controls
  // --------------------------------------------------

  typedef struct packed {
    logic [6:0] spare_hi;
    logic       right_trigger;
    logic       left_trigger;
    logic       left_button;
    logic       bottom_button;
    logic       right_button;
    logic [3:0] spare_lo;
  } pad_view_t;

  typedef struct packed {
    logic [5:0] spare_hi;
    logic       ss_button;
    logic [4:0] spare_mid;
    logic       dpad_up;
    logic       dpad_down;
    logic       dpad_left;
    logic       dpad_right;
  } ss_view_t;

  typedef union packed {
    pad_view_t pad;
    ss_view_t  ss;
  } joy_word_u;

  // The three pet buttons after the savestate mask
  typedef struct packed {
    logic left;
    logic bottom;
    logic right;
  } pad_buttons_t;

  // Registered view of the host side, handed to every later stage
  typedef struct packed {
    ioctl_beat_t  beat;
    logic         rom_download;
    settings_t    settings;
    pad_buttons_t pad;
    logic         osd;
  } host_view_t;

endpackage

// ==== rtl/core_pkg.sv ====
package core_pkg;

  // --------------------------------------------------
  // Program ROM
  // --------------------------------------------------

  // CPU fetches 12-bit instructions from the low bits of each word
  localparam int rom_data_width = 12;

  // --------------------------------------------------
  // Savestate reset hold
  // --------------------------------------------------

  localparam int hold_count_bits = 3;

  // Double-rate CPU ticks to wait before releasing reset
  localparam logic [hold_count_bits-1:0] hold_ticks = 3'd4;

  // --------------------------------------------------
  // Audio
  // --------------------------------------------------

  localparam int audio_bits = 16;

  // Buzzer high level, 14 ones with the top two bits clear
  localparam logic [audio_bits-1:0] audio_on_level = {2'b00, {14{1'b1}}};

  // --------------------------------------------------
  // CPU control
  // --------------------------------------------------

  typedef struct packed {
    logic       reset;
    // K0 port, active low, top bit unused and held at zero
    logic [3:0] keys;
  } cpu_ctrl_t;

endpackage

// ==== rtl/host_input_stage.sv ====
`timescale 1ns/1ps

module host_input_stage (
  input  logic                              clk_sys_117_964,
  input  logic                              ss_begin_reset,
  input  host_pkg::ioctl_beat_t             ioctl,
  input  logic [host_pkg::status_width-1:0] status,
  input  host_pkg::joy_word_u               joystick,
  input  logic                              osd_status,
  output host_pkg::host_view_t              view
);

  import host_pkg::*;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  logic         rom_download_dec;
  settings_t    settings_dec;
  pad_buttons_t pad_dec;

  // ROM download is the stream running with the ROM index
  assign rom_download_dec = ioctl.download && (ioctl.index == rom_index);

  always_comb begin
    settings_dec.external_reset = status[status_reset_bit];
    // Menu option is "sound off" when set
    settings_dec.sound_on       = ~status[status_sound_bit];
    settings_dec.speed          = status[status_speed_msb:status_speed_lsb];
  end

  always_comb begin
    // Pad view of the joystick word
    pad_dec.left   = joystick.pad.left_button;
    pad_dec.bottom = joystick.pad.bottom_button;
    pad_dec.right  = joystick.pad.right_button;
    // Savestate button owns the pad, pet sees nothing
    if (joystick.ss.ss_button) begin
      pad_dec = '0;
    end
  end

  // --------------------------------------------------
  // Register
  // --------------------------------------------------

  always_ff @(posedge clk_sys_117_964) begin
    // Beat payload just follows the stream
    view.beat.index <= ioctl.index;
    view.beat.addr  <= ioctl.addr;
    view.beat.dout  <= ioctl.dout;

    if (ss_begin_reset) begin
      view.beat.download <= 1'b0;
      view.beat.wr       <= 1'b0;
      view.rom_download  <= 1'b0;
      view.settings      <= '0;
      view.pad           <= '0;
      view.osd           <= 1'b0;
    end else begin
      view.beat.download <= ioctl.download;
      view.beat.wr       <= ioctl.wr;
      view.rom_download  <= rom_download_dec;
      view.settings      <= settings_dec;
      view.pad           <= pad_dec;
      // OSD open level, edges are found downstream
      view.osd           <= osd_status;
    end
  end

endmodule

// ==== rtl/rom_loader.sv ====
`timescale 1ns/1ps

module rom_loader #(
  parameter int rom_addr_bits = 13
) (
  input  logic                                clk_sys_117_964,
  input  logic                                ss_begin_reset,
  input  host_pkg::host_view_t                view,
  input  logic [rom_addr_bits-1:0]            cpu_rom_addr,
  output logic [core_pkg::rom_data_width-1:0] rom_data,
  output logic                                rom_ready
);

  import core_pkg::*;

  localparam int rom_words = 2 ** rom_addr_bits;

  // --------------------------------------------------
  // ROM array and write path
  // --------------------------------------------------

  // Program ROM, 16-bit words
  logic [15:0] rom_mem [rom_words];

  logic                     rom_we;
  logic [rom_addr_bits-1:0] rom_waddr;
  logic [15:0]              rom_wdata;

  // Every write beat of a ROM download lands, no wait
  assign rom_we    = view.beat.wr && view.rom_download;

  // Host addresses bytes, ROM is word addressed
  assign rom_waddr = view.beat.addr[rom_addr_bits:1];

  // Host sends words big endian
  assign rom_wdata = {view.beat.dout[7:0], view.beat.dout[15:8]};

  always_ff @(posedge clk_sys_117_964) begin
    if (rom_we) begin
      rom_mem[rom_waddr] <= rom_wdata;
    end
  end

  // CPU read port, one cycle latency
  always_ff @(posedge clk_sys_117_964) begin
    rom_data <= rom_mem[cpu_rom_addr][rom_data_width-1:0];
  end

  // --------------------------------------------------
  // Download done flag
  // --------------------------------------------------

  logic prev_rom_download;

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      prev_rom_download <= 1'b0;
      rom_ready         <= 1'b0;
    end else begin
      prev_rom_download <= view.rom_download;
      // Falling edge of the download, sticky until reset
      if (prev_rom_download && !view.rom_download) begin
        rom_ready <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/savestate_sequencer.sv ====
`timescale 1ns/1ps

module savestate_sequencer #(
  parameter int osd_holdoff_bits = 26
) (
  input  logic clk_sys_117_964,
  input  logic ss_begin_reset,
  input  logic cpu_tick_2x,
  input  logic osd,
  input  logic rom_ready,
  output logic ss_hold,
  output logic begin_save
);

  import core_pkg::*;

  // --------------------------------------------------
  // Reset hold
  // --------------------------------------------------

  // Ticks still to wait before the CPU may run
  logic [hold_count_bits-1:0] hold_count;

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      // Reset restarts the wait
      hold_count <= hold_ticks;
    end else if (cpu_tick_2x && (hold_count != '0)) begin
      hold_count <= hold_count - 1'b1;
    end
  end

  // Held while ticks remain, counter stops at zero
  assign ss_hold = (hold_count != '0);

  // --------------------------------------------------
  // OSD auto-save
  // --------------------------------------------------

  // Minimum gap from OSD close to next auto-save
  localparam logic [osd_holdoff_bits-1:0] holdoff_reload = '1;

  logic                        prev_osd;
  logic [osd_holdoff_bits-1:0] holdoff_timer;
  logic                        osd_rise;
  logic                        osd_fall;
  logic                        save_allowed;

  assign osd_rise = osd && !prev_osd;
  assign osd_fall = prev_osd && !osd;

  // Only with a ROM loaded and no recent close
  assign save_allowed = rom_ready && (holdoff_timer == '0);

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      prev_osd      <= 1'b0;
      holdoff_timer <= '0;
      begin_save    <= 1'b0;
    end else begin
      prev_osd <= osd;

      // One cycle strobe
      begin_save <= osd_rise && save_allowed;

      if (osd_fall) begin
        // OSD closed, start the hold-off
        holdoff_timer <= holdoff_reload;
      end else if (holdoff_timer != '0) begin
        holdoff_timer <= holdoff_timer - 1'b1;
      end
    end
  end

endmodule

// ==== rtl/core_output_stage.sv ====
`timescale 1ns/1ps

module core_output_stage (
  input  logic                            clk_sys_117_964,
  input  logic                            ss_begin_reset,
  input  host_pkg::host_view_t            view,
  input  logic                            ss_hold,
  input  logic                            ext_reset,
  input  logic                            buzzer,
  output core_pkg::cpu_ctrl_t             cpu_ctrl,
  output logic [core_pkg::audio_bits-1:0] audio
);

  import core_pkg::*;

  // Sound only at 1x and 2x speed
  localparam logic [2:0] audio_speed_limit = 3'd2;

  // --------------------------------------------------
  // Next values
  // --------------------------------------------------

  logic                  reset_next;
  logic [3:0]            keys_next;
  logic                  audio_en;
  logic [audio_bits-1:0] audio_next;

  // Any source keeps the CPU in reset, ROM download included
  assign reset_next = ext_reset
                    | view.settings.external_reset
                    | view.rom_download
                    | ss_hold;

  // K0 is active low, left / middle / right
  assign keys_next = {1'b0, ~view.pad.left, ~view.pad.bottom, ~view.pad.right};

  assign audio_en   = view.settings.sound_on && (view.settings.speed < audio_speed_limit);
  assign audio_next = (buzzer && audio_en) ? audio_on_level : '0;

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------

  always_ff @(posedge clk_sys_117_964) begin
    if (ss_begin_reset) begin
      // CPU held in reset, no keys pressed, silent
      cpu_ctrl.reset <= 1'b1;
      cpu_ctrl.keys  <= 4'b0111;
      audio          <= '0;
    end else begin
      cpu_ctrl.reset <= reset_next;
      cpu_ctrl.keys  <= keys_next;
      audio          <= audio_next;
    end
  end

endmodule

// ==== rtl/core_bridge_top.sv ====
`timescale 1ns/1ps

module core_bridge_top #(
  parameter int rom_addr_bits    = 13,
  parameter int osd_holdoff_bits = 26
) (
  input  logic                                clk_sys_117_964,
  input  logic                                ss_begin_reset,
  input  logic                                ext_reset,

  // Host side
  input  host_pkg::ioctl_beat_t               ioctl,
  input  logic [host_pkg::status_width-1:0]   status,
  input  host_pkg::joy_word_u                 joystick,
  input  logic                                osd_status,

  // CPU side
  input  logic [rom_addr_bits-1:0]            cpu_rom_addr,
  input  logic                                cpu_tick_2x,
  input  logic                                buzzer,
  output logic [core_pkg::rom_data_width-1:0] rom_data,
  output logic                                rom_ready,
  output logic                                cpu_reset,
  output logic [3:0]                          cpu_keys,

  // Audio, mono on both channels
  output logic [core_pkg::audio_bits-1:0]     audio_l,
  output logic [core_pkg::audio_bits-1:0]     audio_r,

  // Auto-save request to the savestate controller
  output logic                                begin_save
);

  import host_pkg::*;
  import core_pkg::*;

  host_view_t            view;
  logic                  ss_hold;
  cpu_ctrl_t             cpu_ctrl;
  logic [audio_bits-1:0] audio;

  // --------------------------------------------------
  // Host side
  // --------------------------------------------------

  host_input_stage u_host_input_stage (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .ioctl           (ioctl),
    .status          (status),
    .joystick        (joystick),
    .osd_status      (osd_status),
    .view            (view)
  );

  rom_loader #(
    .rom_addr_bits (rom_addr_bits)
  ) u_rom_loader (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .view            (view),
    .cpu_rom_addr    (cpu_rom_addr),
    .rom_data        (rom_data),
    .rom_ready       (rom_ready)
  );

  // Reset hold and OSD triggered save
  savestate_sequencer #(
    .osd_holdoff_bits (osd_holdoff_bits)
  ) u_savestate_sequencer (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .cpu_tick_2x     (cpu_tick_2x),
    .osd             (view.osd),
    .rom_ready       (rom_ready),
    .ss_hold         (ss_hold),
    .begin_save      (begin_save)
  );

  // --------------------------------------------------
  // CPU side
  // --------------------------------------------------

  core_output_stage u_core_output_stage (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .view            (view),
    .ss_hold         (ss_hold),
    .ext_reset       (ext_reset),
    .buzzer          (buzzer),
    .cpu_ctrl        (cpu_ctrl),
    .audio           (audio)
  );

  assign cpu_reset = cpu_ctrl.reset;
  assign cpu_keys  = cpu_ctrl.keys;
  assign audio_l   = audio;
  assign audio_r   = audio;

endmodule

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// Report counters
// --------------------------------------------------

int checks_run    = 0;
int checks_failed = 0;

// --------------------------------------------------
// Random source
// --------------------------------------------------

// LCG state starting from the fixed seed
logic [31:0] lcg_state = 32'h8e05;

function automatic logic [15:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  // Top half of the state is better mixed than the low bits
  return lcg_state[31:16];
endfunction

// --------------------------------------------------
// Compare and report
// --------------------------------------------------

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] seen);
  checks_run++;
  // X or Z on the DUT side counts as a mismatch
  if (seen !== expected) begin
    checks_failed++;
    $display("Fail at %0d ns: %s expected %0h, seen %0h", $time, name, expected, seen);
  end
endtask

// Failures that are not a wrong value such as an event that never came
task automatic report_error(input string what);
  checks_run++;
  checks_failed++;
  $display("Error at %0d ns: %s", $time, what);
endtask

`endif

// ==== bench/tb_core_bridge.sv ====
`timescale 1ns/1ps

module tb_core_bridge;

  import host_pkg::*;

  localparam int rom_addr_bits    = 13;
  localparam int osd_holdoff_bits = 6;
  localparam int holdoff_cycles   = 2 ** osd_holdoff_bits - 1;
  localparam int key_rounds       = 200;
  localparam int audio_rounds     = 100;
  localparam int rom_words        = 64;
  localparam int rom_reads        = 128;
  localparam int foreign_words    = 8;
  // Test lengths in cycles doubled plus margin
  localparam int timeout_cycles   = 2 * ((4 * 20 + 20) + (key_rounds + 10)
                                    + (audio_rounds * 3 + 10)
                                    + (foreign_words + rom_words * 2 + rom_reads + 40)
                                    + 5 * (holdoff_cycles + 20)) + 1400;

  logic                     clk_sys_117_964 = 1'b0;
  logic                     ss_begin_reset;
  logic                     ext_reset;
  ioctl_beat_t              ioctl;
  logic [status_width-1:0]  status;
  joy_word_u                joystick;
  logic                     osd_status;
  logic [rom_addr_bits-1:0] cpu_rom_addr;
  logic                     cpu_tick_2x;
  logic                     buzzer;
  logic [11:0]              rom_data;
  logic                     rom_ready;
  logic                     cpu_reset;
  logic [3:0]               cpu_keys;
  logic [15:0]              audio_l;
  logic [15:0]              audio_r;
  logic                     begin_save;

  `include "tb_checks.svh"

  // Inputs as driven in one cycle and kept for the latency pipeline
  typedef struct packed {
    logic [15:0]              joy;
    logic [4:0]               stat;
    logic                     buzzer;
    logic                     ext;
    logic                     loading;
    logic [2:0]               ticks;
    logic                     rom_check;
    logic [rom_addr_bits-1:0] rom_addr;
  } stim_t;

  typedef struct packed {
    logic        reset;
    logic [3:0]  keys;
    logic [15:0] audio;
    logic [11:0] rom;
  } expect_t;

  logic        compare_en;
  logic        rom_check;
  int          ticks_driven;
  int          save_pulses;
  int          cycle_count;
  int          test_fails_base;
  logic [15:0] shadow [rom_words];
  stim_t       hist_d1;
  stim_t       hist_d2;
  expect_t     exp_now;

  core_bridge_top #(
    .rom_addr_bits    (rom_addr_bits),
    .osd_holdoff_bits (osd_holdoff_bits)
  ) uut (
    .clk_sys_117_964 (clk_sys_117_964),
    .ss_begin_reset  (ss_begin_reset),
    .ext_reset       (ext_reset),
    .ioctl           (ioctl),
    .status          (status),
    .joystick        (joystick),
    .osd_status      (osd_status),
    .cpu_rom_addr    (cpu_rom_addr),
    .cpu_tick_2x     (cpu_tick_2x),
    .buzzer          (buzzer),
    .rom_data        (rom_data),
    .rom_ready       (rom_ready),
    .cpu_reset       (cpu_reset),
    .cpu_keys        (cpu_keys),
    .audio_l         (audio_l),
    .audio_r         (audio_r),
    .begin_save      (begin_save)
  );

  // 4 ns period
  always #2 clk_sys_117_964 = ~clk_sys_117_964;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // slow went through both stages, fast only the output stage
  function automatic expect_t reference(input stim_t slow, input stim_t fast,
                                        input logic [15:0] rom_raw);
    expect_t    e;
    logic [2:0] pad;
    logic       sound;
    // Savestate button on bit 9 hides the pet buttons
    pad     = slow.joy[9] ? 3'b000 : {slow.joy[6], slow.joy[5], slow.joy[4]};
    e.keys  = {1'b0, ~pad};
    e.reset = fast.ext | slow.stat[0] | slow.loading | (slow.ticks < 3'd4);
    // Status bit 1 mutes, speed 2 and up mutes
    sound   = !slow.stat[1] && (slow.stat[4:2] < 3'd2);
    e.audio = (fast.buzzer && sound) ? 16'h3fff : 16'h0000;
    // Swapped word is {dout[7:0], dout[15:8]}, CPU gets its low 12 bits
    e.rom   = {rom_raw[3:0], rom_raw[15:8]};
    return e;
  endfunction

  function automatic stim_t sample_stim();
    stim_t s;
    s.joy       = joystick;
    s.stat      = status[4:0];
    s.buzzer    = buzzer;
    s.ext       = ext_reset;
    s.loading   = ioctl.download && (ioctl.index == 16'd0);
    s.ticks     = (ticks_driven > 7) ? 3'd7 : 3'(ticks_driven);
    s.rom_check = rom_check;
    s.rom_addr  = cpu_rom_addr;
    return s;
  endfunction

  // --------------------------------------------------
  // Comparing process at the falling edge where outputs are stable
  // --------------------------------------------------

  always @(negedge clk_sys_117_964) begin
    if (compare_en) begin
      exp_now = reference(hist_d2, hist_d1, shadow[hist_d1.rom_addr[5:0]]);
      check_value("cpu_reset", exp_now.reset, cpu_reset);
      check_value("cpu_keys", exp_now.keys, cpu_keys);
      check_value("audio_l", exp_now.audio, audio_l);
      check_value("audio_r", exp_now.audio, audio_r);
      if (hist_d1.rom_check) begin
        check_value("rom_data", exp_now.rom, rom_data);
      end
    end
    if (begin_save === 1'b1) begin
      save_pulses++;
    end
    hist_d2 = hist_d1;
    hist_d1 = sample_stim();
  end

  // Run limit
  always @(posedge clk_sys_117_964) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic finish_test(input string name);
    $display("Test %s done, %0d failures", name, checks_failed - test_fails_base);
    test_fails_base = checks_failed;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin : main_sequence
    int          i;
    int          waited;
    int          base;
    logic [15:0] r;
    ss_begin_reset  = 1'b1;
    ext_reset       = 1'b0;
    ioctl           = '0;
    status          = '0;
    joystick        = '0;
    osd_status      = 1'b0;
    cpu_rom_addr    = '0;
    cpu_tick_2x     = 1'b0;
    buzzer          = 1'b0;
    compare_en      = 1'b0;
    rom_check       = 1'b0;
    ticks_driven    = 0;
    save_pulses     = 0;
    cycle_count     = 0;
    test_fails_base = 0;
    hist_d1         = '0;
    hist_d2         = '0;
    repeat (4) @(posedge clk_sys_117_964);
    ss_begin_reset <= 1'b0;
    // Pipeline fills with idle inputs before checking starts
    repeat (3) @(posedge clk_sys_117_964);
    compare_en <= 1'b1;

    // Reset hold with three ticks then the fourth
    for (i = 0; i < 4; i++) begin
      r = next_random();
      repeat (2 + r[3:0]) @(posedge clk_sys_117_964);
      cpu_tick_2x <= 1'b1;
      ticks_driven++;
      @(posedge clk_sys_117_964);
      cpu_tick_2x <= 1'b0;
      if (i == 2) begin
        repeat (10) @(negedge clk_sys_117_964);
        check_value("cpu_reset after three ticks", 1, cpu_reset);
      end
    end
    // Tick counted at the edge just passed, cpu_reset one edge later
    waited = 0;
    do begin
      @(negedge clk_sys_117_964);
      waited++;
    end while (cpu_reset !== 1'b0 && waited < 10);
    if (cpu_reset !== 1'b0) begin
      report_error("cpu_reset did not fall after the fourth tick");
    end else begin
      check_value("cpu_reset release delay", 2, waited);
    end
    finish_test("reset_hold");

    // Auto-save before any ROM gives no pulse
    @(posedge clk_sys_117_964);
    osd_status <= 1'b1;
    repeat (6) @(posedge clk_sys_117_964);
    check_value("begin_save pulses before rom_ready", 0, save_pulses);
    osd_status <= 1'b0;
    repeat (holdoff_cycles + 10) @(posedge clk_sys_117_964);
    finish_test("save_before_rom");

    // Keys with an occasional external reset
    for (i = 0; i < key_rounds; i++) begin
      @(posedge clk_sys_117_964);
      joystick  <= next_random();
      r = next_random();
      ext_reset <= (r[2:0] == 3'd0);
    end
    @(posedge clk_sys_117_964);
    joystick  <= '0;
    ext_reset <= 1'b0;
    repeat (3) @(posedge clk_sys_117_964);
    finish_test("keys");

    // Audio with each setting held for 3 cycles
    for (i = 0; i < audio_rounds; i++) begin
      @(posedge clk_sys_117_964);
      r = next_random();
      buzzer <= r[0];
      status <= {next_random(), next_random(), next_random(), next_random()};
      repeat (2) @(posedge clk_sys_117_964);
    end
    @(posedge clk_sys_117_964);
    buzzer <= 1'b0;
    status <= '0;
    repeat (3) @(posedge clk_sys_117_964);
    finish_test("audio");

    // A download with another index leaves the CPU running and rom_ready low
    @(posedge clk_sys_117_964);
    ioctl.download <= 1'b1;
    ioctl.index    <= 16'd1;
    for (i = 0; i < foreign_words; i++) begin
      @(posedge clk_sys_117_964);
      r = next_random();
      ioctl.wr   <= 1'b1;
      ioctl.addr <= 27'(i * 2);
      ioctl.dout <= r;
    end
    @(posedge clk_sys_117_964);
    ioctl.wr       <= 1'b0;
    ioctl.download <= 1'b0;
    repeat (3) @(posedge clk_sys_117_964);

    // ROM download at byte addresses two apart with random gaps in wr
    @(negedge clk_sys_117_964);
    check_value("rom_ready before download", 0, rom_ready);
    @(posedge clk_sys_117_964);
    ioctl.download <= 1'b1;
    ioctl.index    <= 16'd0;
    i = 0;
    while (i < rom_words) begin
      @(posedge clk_sys_117_964);
      r = next_random();
      if (r[1:0] == 2'd0) begin
        ioctl.wr <= 1'b0;
      end else begin
        r = next_random();
        ioctl.wr   <= 1'b1;
        ioctl.addr <= 27'(i * 2);
        ioctl.dout <= r;
        shadow[i] = r;
        i++;
      end
    end
    @(posedge clk_sys_117_964);
    ioctl.wr       <= 1'b0;
    ioctl.download <= 1'b0;
    // First stage sees the fall, then rom_ready one edge after that
    waited = 0;
    do begin
      @(negedge clk_sys_117_964);
      waited++;
    end while (rom_ready !== 1'b1 && waited < 10);
    if (rom_ready !== 1'b1) begin
      report_error("rom_ready did not rise after the download ended");
    end else begin
      check_value("rom_ready delay", 3, waited);
    end
    // Sequential pass, then random addresses
    for (i = 0; i < rom_reads; i++) begin
      @(posedge clk_sys_117_964);
      r = next_random();
      rom_check    <= 1'b1;
      cpu_rom_addr <= (i < rom_words) ? rom_addr_bits'(i) : rom_addr_bits'(r[5:0]);
    end
    @(posedge clk_sys_117_964);
    rom_check <= 1'b0;
    repeat (2) @(negedge clk_sys_117_964);
    check_value("rom_ready after reads", 1, rom_ready);
    finish_test("rom_load");

    // Auto-save with hold-off
    @(posedge clk_sys_117_964);
    base = save_pulses;
    osd_status <= 1'b1;
    repeat (6) @(posedge clk_sys_117_964);
    check_value("begin_save pulses on first open", 1, save_pulses - base);
    osd_status <= 1'b0;
    repeat (10) @(posedge clk_sys_117_964);
    osd_status <= 1'b1;
    repeat (6) @(posedge clk_sys_117_964);
    check_value("begin_save pulses inside hold-off", 1, save_pulses - base);
    osd_status <= 1'b0;
    repeat (holdoff_cycles + 17) @(posedge clk_sys_117_964);
    osd_status <= 1'b1;
    repeat (6) @(posedge clk_sys_117_964);
    check_value("begin_save pulses after hold-off", 2, save_pulses - base);
    osd_status <= 1'b0;
    repeat (4) @(posedge clk_sys_117_964);
    finish_test("auto_save");

    $display("Summary: %0d checks, %0d failed", checks_run, checks_failed);
    if (checks_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+bench
rtl/host_pkg.sv
rtl/core_pkg.sv
rtl/host_input_stage.sv
rtl/rom_loader.sv
rtl/savestate_sequencer.sv
rtl/core_output_stage.sv
rtl/core_bridge_top.sv
bench/tb_core_bridge.sv
